/* hw/fetch_pkg.sv */
package fetch_pkg;

    localparam int XLEN = 32;

    // Canonical addi x0, x0, 0 used for every bubble.
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Predictor tables are indexed by pc[6:1] and tagged with the bits above.
    localparam int BP_INDEX_BITS = 6;
    localparam int BP_ENTRIES    = 1 << BP_INDEX_BITS;
    localparam int BP_TAG_BITS   = XLEN - BP_INDEX_BITS - 1;

    typedef enum logic [1:0] {
        KIND_OTHER,
        KIND_BRANCH,
        KIND_JAL
    } instr_kind_e;

    // Major opcodes known to the predecoder. OP_C_BRANCH covers c.beqz and c.bnez.
    typedef enum logic [1:0] {
        OP_OTHER,
        OP_BRANCH,
        OP_JAL,
        OP_C_BRANCH
    } opcode_e;

endpackage

/* hw/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       stall_i,
    input  logic                       hold_i,
    input  logic                       step_half_i,
    input  logic                       mispredict_i,
    input  logic [fetch_pkg::XLEN-1:0] resolve_target_i,
    input  logic                       jal_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] jal_target_i,
    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_step;

    // A word fetched at a +2 target only yields its upper half.
    assign pc_step = step_half_i ? XLEN'(2) : XLEN'(4);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (mispredict_i) begin
            pc_q <= resolve_target_i;  // Resolved branch beats everything else.
        end else if (jal_valid_i) begin
            pc_q <= jal_target_i;
        end else if (pred_taken_i) begin
            pc_q <= pred_target_i;
        end else if (!stall_i && !hold_i) begin
            pc_q <= pc_q + pc_step;
        end
    end

    assign fetch_pc_o = pc_q;

    // Targets come from outside, so alignment has to hold across all redirect sources.
    a_pc_halfword: assert property (
        @(posedge clk_i) disable iff (reset_i) !fetch_pc_o[0]
    );

endmodule

/* hw/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       word_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] word_i,
    input  logic [fetch_pkg::XLEN-1:0] word_pc_i,
    input  logic                       flush_i,
    input  logic                       consume_i,
    output logic                       head_valid_o,
    output logic [fetch_pkg::XLEN-1:0] head_instr_o,
    output logic [fetch_pkg::XLEN-1:0] head_pc_o,
    output logic                       hold_o,
    output logic                       step_half_o
);
    import fetch_pkg::*;

    typedef enum logic {
        Q_EMPTY,
        Q_HALF
    } q_state_e;

    q_state_e        state_q;
    logic [15:0]     half_q;
    logic [XLEN-1:0] half_pc_q;
    logic [15:0]     word_lo;
    logic [15:0]     word_hi;
    logic            half_full;
    logic            word_head;
    logic            accept;

    assign word_lo   = word_i[15:0];
    assign word_hi   = word_i[31:16];
    assign half_full = (half_q[1:0] == 2'b11);  // Pending half opens a 32-bit instruction.

    always_comb begin
        head_valid_o = 1'b0;
        head_instr_o = {16'b0, word_lo};
        head_pc_o    = word_pc_i;
        word_head    = 1'b0;
        if (state_q == Q_EMPTY) begin
            if (word_valid_i && !word_pc_i[1]) begin
                head_valid_o = 1'b1;
                word_head    = 1'b1;
                if (word_lo[1:0] == 2'b11) begin
                    head_instr_o = word_i;
                end
            end else if (word_valid_i && word_hi[1:0] != 2'b11) begin
                // Lower half belongs to the old path and is dropped.
                head_valid_o = 1'b1;
                word_head    = 1'b1;
                head_instr_o = {16'b0, word_hi};
            end
        end else if (!half_full) begin
            head_valid_o = 1'b1;
            head_instr_o = {16'b0, half_q};
            head_pc_o    = half_pc_q;
        end else if (word_valid_i) begin
            head_valid_o = 1'b1;
            word_head    = 1'b1;
            head_instr_o = {word_lo, half_q};  // Split instruction completed.
            head_pc_o    = half_pc_q;
        end
    end

    // A waiting compressed half, or an unconsumed head taken from the word, blocks the word.
    assign hold_o      = (state_q == Q_HALF && !half_full) || (word_head && !consume_i);
    assign accept      = word_valid_i && !hold_o;
    assign step_half_o = (state_q == Q_EMPTY) && word_pc_i[1];

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q <= Q_EMPTY;
        end else if (state_q == Q_EMPTY) begin
            if (accept && !word_pc_i[1] && word_lo[1:0] != 2'b11) begin
                state_q <= Q_HALF;
            end else if (accept && word_pc_i[1] && word_hi[1:0] == 2'b11) begin
                state_q <= Q_HALF;
            end
        end else if (!half_full && consume_i) begin
            state_q <= Q_EMPTY;
        end
    end

    // The stored half is always the upper half of an accepted word.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            half_q    <= word_hi;
            half_pc_q <= {word_pc_i[XLEN-1:2], 2'b10};
        end
    end

    // The top must not hand over a stale word right after a redirect.
    a_flush_empties: assert property (
        @(posedge clk_i) disable iff (reset_i) flush_i |=> !head_valid_o
    );

endmodule

/* hw/predecoder.sv */
`timescale 1ns/1ps

module predecoder (
    input  logic [fetch_pkg::XLEN-1:0] instr_i,
    output fetch_pkg::instr_kind_e     kind_o,
    output logic [fetch_pkg::XLEN-1:0] imm_target_offset_o
);
    import fetch_pkg::*;

    opcode_e opcode;

    always_comb begin
        opcode = OP_OTHER;
        if (instr_i[1:0] == 2'b11) begin
            if (instr_i[6:0] == 7'b1100011) opcode = OP_BRANCH;
            if (instr_i[6:0] == 7'b1101111) opcode = OP_JAL;
        end else if (instr_i[1:0] == 2'b01 && instr_i[15:14] == 2'b11) begin
            opcode = OP_C_BRANCH;  // Quadrant 1, funct3 110 or 111.
        end
    end

    always_comb begin
        kind_o              = KIND_OTHER;
        imm_target_offset_o = '0;
        case (opcode)
            OP_BRANCH: begin
                kind_o              = KIND_BRANCH;
                imm_target_offset_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                       instr_i[11:8], 1'b0};
            end
            OP_C_BRANCH: begin
                kind_o              = KIND_BRANCH;
                imm_target_offset_o = {{24{instr_i[12]}}, instr_i[6:5], instr_i[2],
                                       instr_i[11:10], instr_i[4:3], 1'b0};
            end
            OP_JAL: begin
                kind_o              = KIND_JAL;
                imm_target_offset_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                       instr_i[30:21], 1'b0};
            end
            default: begin
                kind_o = KIND_OTHER;
            end
        endcase
    end

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [fetch_pkg::XLEN-1:0] lookup_pc_i,
    input  fetch_pkg::instr_kind_e     lookup_kind_i,
    input  logic                       lookup_valid_i,
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o,
    input  logic                       update_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] update_pc_i,
    input  logic                       update_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] update_target_i
);
    import fetch_pkg::*;

    logic [1:0]               cnt_q    [BP_ENTRIES];
    logic                     valid_q  [BP_ENTRIES];
    logic [BP_TAG_BITS-1:0]   tag_q    [BP_ENTRIES];
    logic [XLEN-1:0]          target_q [BP_ENTRIES];
    logic [BP_INDEX_BITS-1:0] look_idx;
    logic [BP_INDEX_BITS-1:0] upd_idx;
    logic [BP_TAG_BITS-1:0]   look_tag;
    logic [BP_TAG_BITS-1:0]   upd_tag;
    logic                     hit;

    assign look_idx = lookup_pc_i[BP_INDEX_BITS:1];
    assign look_tag = lookup_pc_i[XLEN-1:BP_INDEX_BITS+1];
    assign upd_idx  = update_pc_i[BP_INDEX_BITS:1];
    assign upd_tag  = update_pc_i[XLEN-1:BP_INDEX_BITS+1];

    assign hit = valid_q[look_idx] && (tag_q[look_idx] == look_tag);

    // Counter values 2 and 3 mean taken.
    assign pred_taken_o  = lookup_valid_i && (lookup_kind_i == KIND_BRANCH) &&
                           cnt_q[look_idx][1] && hit;
    assign pred_target_o = target_q[look_idx];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                cnt_q[i]   <= 2'b01;  // Weakly not taken.
                valid_q[i] <= 1'b0;
            end
        end else if (update_valid_i) begin
            if (update_taken_i) begin
                valid_q[upd_idx] <= 1'b1;
                if (cnt_q[upd_idx] != 2'b11) begin
                    cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
                end
            end else if (cnt_q[upd_idx] != 2'b00) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
            end
        end
    end

    // Only taken outcomes write the target buffer.
    always_ff @(posedge clk_i) begin
        if (update_valid_i && update_taken_i) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update_target_i;
        end
    end

    // A taken prediction must send fetch to a halfword boundary.
    a_pred_target_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i) pred_taken_o |-> !pred_target_o[0]
    );

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       stall_i,
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
    input  logic [fetch_pkg::XLEN-1:0] imem_data_i,
    input  logic                       imem_ready_i,
    input  logic                       update_valid_i,
    input  logic                       update_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] update_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] resolve_target_i,
    input  logic                       mispredict_i,
    input  logic                       jal_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] jal_target_i,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic                       pred_taken_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] req_pc_q;
    logic            flush_q;
    logic            word_valid;
    logic            head_valid;
    logic [XLEN-1:0] head_instr;
    logic [XLEN-1:0] head_pc;
    logic            q_hold;
    logic            q_step_half;
    instr_kind_e     head_kind;
    logic [XLEN-1:0] head_offset;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
    logic            consume;
    logic            pred_fire;
    logic            flush;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr_q;
    logic            pred_q;

    assign imem_addr_o = {fetch_pc[XLEN-1:2], 2'b00};

    // The returning word belongs to last cycle's PC; it only counts if the PC is still there.
    assign word_valid = imem_ready_i && !flush_q && !stall_i && (req_pc_q == fetch_pc);

    assign consume   = head_valid && !stall_i && !mispredict_i && !jal_valid_i;
    assign pred_fire = pred_taken && consume;  // The branch leaves first, then we jump.
    assign flush     = mispredict_i || jal_valid_i || pred_fire;

    pc_gen u_pc_gen (
        .clk_i(clk_i), .reset_i(reset_i),
        .stall_i(!word_valid), .hold_i(q_hold), .step_half_i(q_step_half),
        .mispredict_i(mispredict_i), .resolve_target_i(resolve_target_i),
        .jal_valid_i(jal_valid_i), .jal_target_i(jal_target_i),
        .pred_taken_i(pred_fire), .pred_target_i(pred_target),
        .fetch_pc_o(fetch_pc)
    );

    instr_queue u_instr_queue (
        .clk_i(clk_i), .reset_i(reset_i),
        .word_valid_i(word_valid), .word_i(imem_data_i), .word_pc_i(req_pc_q),
        .flush_i(flush), .consume_i(consume),
        .head_valid_o(head_valid), .head_instr_o(head_instr), .head_pc_o(head_pc),
        .hold_o(q_hold), .step_half_o(q_step_half)
    );

    predecoder u_predecoder (
        .instr_i(head_instr), .kind_o(head_kind), .imm_target_offset_o(head_offset)
    );

    branch_predictor u_branch_predictor (
        .clk_i(clk_i), .reset_i(reset_i),
        .lookup_pc_i(head_pc), .lookup_kind_i(head_kind), .lookup_valid_i(head_valid),
        .pred_taken_o(pred_taken), .pred_target_o(pred_target),
        .update_valid_i(update_valid_i), .update_pc_i(update_pc_i),
        .update_taken_i(update_taken_i), .update_target_i(resolve_target_i)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            flush_q <= 1'b1;  // Whatever memory returns during reset is ignored.
            instr_q <= NOP_INSTR;
            pred_q  <= 1'b0;
        end else begin
            flush_q <= flush;
            if (mispredict_i || jal_valid_i) begin
                instr_q <= NOP_INSTR;
                pred_q  <= 1'b0;
            end else if (!stall_i) begin
                instr_q <= head_valid ? head_instr : NOP_INSTR;
                pred_q  <= head_valid && pred_taken;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        req_pc_q <= fetch_pc;
        if (consume) begin
            pc_q <= head_pc;
        end
    end

    assign pc_o         = pc_q;
    assign instr_o      = instr_q;
    assign pred_taken_o = pred_q;

    // Predicted targets come from resolution and must agree with the encoded offset.
    a_pred_target: assert property (
        @(posedge clk_i) disable iff (reset_i)
        pred_taken |-> (pred_target == head_pc + head_offset)
    );

endmodule

/* tests/tb_fetch_stage.sv */
`timescale 1ns/1ps

module tb_fetch_stage;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] BRANCH_PC     = 32'h0000_0062;
    localparam logic [XLEN-1:0] BRANCH_TARGET = 32'h0000_0082;
    localparam logic [XLEN-1:0] BRANCH_INSTR  = 32'h0220_9063;  // bne x1, x2, +32.
    localparam int CHECKED_INSTRS = 66;
    localparam int CYCLE_LIMIT    = 40 * CHECKED_INSTRS;

    logic            clk_i;
    logic            reset_i;
    logic            stall_i;
    logic [XLEN-1:0] imem_addr_o;
    logic [XLEN-1:0] imem_data_i;
    logic            imem_ready_i;
    logic            update_valid_i;
    logic            update_taken_i;
    logic [XLEN-1:0] update_pc_i;
    logic [XLEN-1:0] resolve_target_i;
    logic            mispredict_i;
    logic            jal_valid_i;
    logic [XLEN-1:0] jal_target_i;
    logic [XLEN-1:0] pc_o;
    logic [XLEN-1:0] instr_o;
    logic            pred_taken_o;

    logic [XLEN-1:0] mem [64];
    logic [1:0]      ref_cnt [64];
    logic            ref_valid [64];
    logic [XLEN-1:0] ref_pc [64];
    logic [XLEN-1:0] ref_target [64];
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] held_pc;
    logic [XLEN-1:0] held_instr;
    logic            bubble_due = 1'b0;
    logic            stall_prev = 1'b1;
    integer          seed = 25;
    int              errors = 0;
    int              delivered = 0;
    int              cycles = 0;

    fetch_stage UUT (
        .clk_i(clk_i), .reset_i(reset_i), .stall_i(stall_i),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i), .imem_ready_i(imem_ready_i),
        .update_valid_i(update_valid_i), .update_taken_i(update_taken_i),
        .update_pc_i(update_pc_i), .resolve_target_i(resolve_target_i),
        .mispredict_i(mispredict_i), .jal_valid_i(jal_valid_i), .jal_target_i(jal_target_i),
        .pc_o(pc_o), .instr_o(instr_o), .pred_taken_o(pred_taken_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [15:0] half_at(input logic [XLEN-1:0] pc);
        return pc[1] ? mem[pc[7:2]][31:16] : mem[pc[7:2]][15:0];
    endfunction

    // Instruction at pc in program order with compressed ones zero-extended.
    function automatic logic [XLEN-1:0] instr_at(input logic [XLEN-1:0] pc);
        logic [15:0] lo;
        lo = half_at(pc);
        if (lo[1:0] == 2'b11) begin
            return {half_at(pc + 32'd2), lo};
        end
        return {16'b0, lo};
    endfunction

    function automatic logic predict(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr);
        logic [5:0] idx;
        logic       branch;
        idx    = pc[6:1];
        branch = (instr[6:0] == 7'b1100011) || (instr[1:0] == 2'b01 && instr[15:14] == 2'b11);
        return branch && ref_valid[idx] && ref_pc[idx] == pc && ref_cnt[idx] >= 2'd2;
    endfunction

    task automatic train(input logic [XLEN-1:0] pc, input logic taken,
                         input logic [XLEN-1:0] target);
        logic [5:0] idx;
        idx = pc[6:1];
        if (taken) begin
            if (ref_cnt[idx] != 2'd3) ref_cnt[idx] = ref_cnt[idx] + 2'd1;
            ref_valid[idx]  = 1'b1;
            ref_pc[idx]     = pc;
            ref_target[idx] = target;
        end else if (ref_cnt[idx] != 2'd0) begin
            ref_cnt[idx] = ref_cnt[idx] - 2'd1;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] expected);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
        errors = errors + 1;
    endtask

    task automatic put_half(input logic [XLEN-1:0] pc, input logic [15:0] half);
        if (pc[1]) mem[pc[7:2]][31:16] = half;
        else mem[pc[7:2]][15:0] = half;
    endtask

    // The first 64 bytes hold aligned 32-bit xori.
    // Beyond them c.addi mixes with 32-bit xori, some split across words.
    initial begin : memory_model
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] addr_q;
        imem_data_i  = '0;
        imem_ready_i = 1'b0;
        addr_q       = '0;
        pc           = '0;
        while (pc < 32'h100) begin
            if (pc == BRANCH_PC) word = BRANCH_INSTR;
            else if (pc < 32'h40 || (pc[3] ^ pc[1])) word = {pc[11:0], 13'h0081, 7'b0010011};
            else word = {16'b0, 3'b000, pc[6], pc[7], 4'b0001, pc[5:1], 2'b01};
            put_half(pc, word[15:0]);
            if (word[1:0] == 2'b11) begin
                put_half(pc + 32'd2, word[31:16]);
                pc = pc + 32'd4;
            end else begin
                pc = pc + 32'd2;
            end
        end
        forever begin
            @(negedge clk_i);
            if (imem_addr_o[1:0] !== 2'b00) begin
                report_mismatch("imem_addr_o[1:0]", 32'(imem_addr_o[1:0]), 32'd0);
            end
            imem_data_i  = mem[addr_q[7:2]];  // Word for last cycle's address.
            imem_ready_i = ($random(seed) & 3) != 0;
            addr_q       = imem_addr_o;
        end
    end

    always @(posedge clk_i) begin : compare
        logic [XLEN-1:0] exp_instr;
        logic            exp_pred;
        if (reset_i) begin
            exp_pc     = RESET_PC;
            bubble_due = 1'b0;
            for (int i = 0; i < 64; i++) begin
                ref_cnt[i]   = 2'd1;
                ref_valid[i] = 1'b0;
            end
        end else begin
            if (bubble_due) begin
                if (instr_o !== NOP_INSTR) report_mismatch("instr_o", instr_o, NOP_INSTR);
            end else if (!stall_prev && instr_o !== NOP_INSTR) begin
                exp_instr = instr_at(exp_pc);
                exp_pred  = predict(exp_pc, exp_instr);
                if (pc_o !== exp_pc) report_mismatch("pc_o", pc_o, exp_pc);
                if (instr_o !== exp_instr) report_mismatch("instr_o", instr_o, exp_instr);
                if (pred_taken_o !== exp_pred) begin
                    report_mismatch("pred_taken_o", 32'(pred_taken_o), 32'(exp_pred));
                end
                if (exp_pred) exp_pc = ref_target[exp_pc[6:1]];
                else exp_pc = exp_pc + ((exp_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
                delivered = delivered + 1;
            end
            bubble_due = mispredict_i || jal_valid_i;
            if (mispredict_i) exp_pc = resolve_target_i;
            else if (jal_valid_i) exp_pc = jal_target_i;
            if (update_valid_i) train(update_pc_i, update_taken_i, resolve_target_i);
        end
        stall_prev = stall_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d instructions checked and %0d errors",
                     cycles, delivered, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic wait_for(input int count);
        int target;
        target = delivered + count;
        while (delivered < target) @(negedge clk_i);
    endtask

    // A resolved jal, optionally carrying a branch outcome in the same cycle.
    task automatic jump(input logic [XLEN-1:0] target, input logic train_branch,
                        input logic taken);
        jal_valid_i      = 1'b1;
        jal_target_i     = target;
        update_valid_i   = train_branch;
        update_taken_i   = taken;
        update_pc_i      = BRANCH_PC;
        resolve_target_i = BRANCH_TARGET;
        @(negedge clk_i);
        jal_valid_i    = 1'b0;
        update_valid_i = 1'b0;
    endtask

    initial begin
        reset_i          = 1'b1;
        stall_i          = 1'b0;
        update_valid_i   = 1'b0;
        update_taken_i   = 1'b0;
        update_pc_i      = '0;
        resolve_target_i = '0;
        mispredict_i     = 1'b0;
        jal_valid_i      = 1'b0;
        jal_target_i     = '0;
        repeat (4) @(negedge clk_i);
        if (instr_o !== NOP_INSTR) report_mismatch("instr_o", instr_o, NOP_INSTR);
        if (pred_taken_o !== 1'b0) begin
            report_mismatch("pred_taken_o", 32'(pred_taken_o), 32'd0);
        end
        reset_i = 1'b0;
        @(negedge clk_i);
        if (imem_addr_o !== RESET_PC) report_mismatch("imem_addr_o", imem_addr_o, RESET_PC);
        wait_for(30);
        stall_i = 1'b1;
        @(negedge clk_i);
        held_pc    = pc_o;
        held_instr = instr_o;
        repeat (5) begin
            @(negedge clk_i);
            if (pc_o !== held_pc) report_mismatch("pc_o", pc_o, held_pc);
            if (instr_o !== held_instr) report_mismatch("instr_o", instr_o, held_instr);
        end
        stall_i = 1'b0;
        jump(32'h46, 1'b0, 1'b0);  // Split 32-bit instruction at a +2 target.
        wait_for(8);
        mispredict_i     = 1'b1;
        resolve_target_i = 32'h8A;
        @(negedge clk_i);
        mispredict_i = 1'b0;
        wait_for(8);
        // One taken outcome makes the branch predicted taken on the next pass.
        jump(32'h52, 1'b1, 1'b1);
        wait_for(10);
        jump(32'h52, 1'b1, 1'b0);
        jump(32'h52, 1'b1, 1'b0);
        wait_for(10);
        $display("Checked %0d instructions, %0d errors", delivered, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/instr_queue.sv
hw/predecoder.sv
hw/branch_predictor.sv
hw/fetch_stage.sv
tests/tb_fetch_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_stage -f build.f

output=$(./obj_dir/Vtb_fetch_stage 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx 'TEST PASS'
